// File: include/chain_macros.svh
`ifndef CHAIN_MACROS_SVH
`define CHAIN_MACROS_SVH

// Data path widths
`define SAMPLE_WIDTH 16     // Sample bus and memory data
`define ADDR_WIDTH   13     // Memory address, same as board row width
`define SEQ_WIDTH    12     // Sample region holds 2**SEQ_WIDTH words

// Traffic burst
`define BURST_LEN    32     // Words per burst

// Arbiter buffering
// Pointers wrap naturally, so keep this a power of two
`define FIFO_DEPTH   8

// Address map
`define TRAFFIC_BASE 'h1000 // Traffic region starts right above the sample region

// Pattern data is the address XORed with this mask
`define TRAFFIC_MASK 'hA5A5

`endif

// File: rtl/sample_pkg.sv
`default_nettype none

`include "chain_macros.svh"

package sample_pkg;

    // One word from the sample bus
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // Running index of captured samples, wraps with the sample region
    typedef logic [`SEQ_WIDTH-1:0] sample_seq_t;

    // One captured sample
    typedef struct packed {
        sample_seq_t seq;   // Also the word offset in the sample region
        sample_t     data;
    } sample_rec_t;

endpackage

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

`include "chain_macros.svh"

package mem_pkg;

    // Memory write port
    typedef logic [`ADDR_WIDTH-1:0]   mem_addr_t;
    typedef logic [`SAMPLE_WIDTH-1:0] mem_data_t;

    // Producer that issued a write
    typedef enum logic {
        SRC_SAMPLE  = 1'b0,
        SRC_TRAFFIC = 1'b1
    } mem_src_e;

    // One write command
    typedef struct packed {
        mem_addr_t addr;
        mem_data_t data;
    } mem_cmd_t;

endpackage

`default_nettype wire

// File: rtl/chain_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

// Small FIFO with first-word read; pushes into a full buffer are lost
module chain_fifo #(
    parameter type payload_t = logic
) (
    input  wire           pad_clk,
    input  wire           pad_resetn,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      pop_data,
    output logic          empty,
    output logic          overflow
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == (PTR_W + 1)'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign pop_data = mem[rd_ptr];  // Head entry, valid while not empty

    always_ff @(posedge pad_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge pad_clk) begin
        if (!pad_resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;   // Sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sample_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

// Turns every change on the async sample bus into one sample record
module sample_capture
    import sample_pkg::*;
(
    input  wire            pad_clk,
    input  wire            pad_resetn,
    input  wire sample_t   sample_data_async,
    output logic           sample_stb,
    output sample_rec_t    sample_rec
);

    sample_t     sync_q1;   // First synchronizer stage
    sample_t     sync_q2;   // Second stage, safe to use from here on
    sample_t     last_q;    // Value of the previous record
    sample_seq_t seq_q;     // Seq of the next record
    logic        changed;

    // Compare stage against what was last recorded
    assign changed = (sync_q2 != last_q);

    always_ff @(posedge pad_clk) begin
        if (!pad_resetn) begin
            sync_q1    <= '0;
            sync_q2    <= '0;
            last_q     <= '0;   // A bus held at zero gives no record
            seq_q      <= '0;
            sample_stb <= 1'b0;
        end else begin
            sync_q1    <= sample_data_async;
            sync_q2    <= sync_q1;
            last_q     <= sync_q2;
            sample_stb <= changed;  // One cycle per change
            if (changed) begin
                seq_q <= seq_q + 1'b1;  // Wraps at the end of the region
            end
        end
    end

    // Record is only sampled by the arbiter together with the strobe
    always_ff @(posedge pad_clk) begin
        if (changed) begin
            sample_rec.seq  <= seq_q;
            sample_rec.data <= sync_q2;
        end
    end

endmodule

`default_nettype wire

// File: rtl/traffic_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

// Fixed burst of pattern writes over the traffic region, started by a switch
module traffic_gen
    import mem_pkg::*;
(
    input  wire      pad_clk,
    input  wire      pad_resetn,
    input  wire      enable_async,
    output logic     traffic_stb,
    output mem_cmd_t traffic_cmd,
    output logic     burst_busy
);

    localparam int IDX_W = $clog2(`BURST_LEN);

    logic             en_q1;    // Synchronizer
    logic             en_q2;
    logic             en_q3;    // Previous synchronized level
    logic             rise;
    logic [IDX_W-1:0] idx_q;    // Word index inside the burst
    mem_addr_t        addr;

    assign rise = en_q2 & ~en_q3;

    always_ff @(posedge pad_clk) begin
        if (!pad_resetn) begin
            en_q1      <= 1'b0;
            en_q2      <= 1'b0;
            en_q3      <= 1'b0;
            burst_busy <= 1'b0;
            idx_q      <= '0;
        end else begin
            en_q1 <= enable_async;
            en_q2 <= en_q1;
            en_q3 <= en_q2;
            if (!burst_busy) begin
                if (rise) begin     // Edges while busy are ignored
                    burst_busy <= 1'b1;
                    idx_q      <= '0;
                end
            end else begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == IDX_W'(`BURST_LEN - 1)) begin
                    burst_busy <= 1'b0;     // Last word goes out this cycle
                end
            end
        end
    end

    // One write per busy cycle
    assign addr        = mem_addr_t'(`TRAFFIC_BASE) + mem_addr_t'(idx_q);
    assign traffic_stb = burst_busy;

    always_comb begin
        traffic_cmd.addr = addr;
        traffic_cmd.data = mem_data_t'(addr) ^ mem_data_t'(`TRAFFIC_MASK);
    end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

// Buffers both producers and issues at most one memory write per cycle
module mem_arbiter
    import sample_pkg::*, mem_pkg::*;
(
    input  wire              pad_clk,
    input  wire              pad_resetn,
    input  wire              sample_stb,
    input  wire sample_rec_t sample_rec,
    input  wire              traffic_stb,
    input  wire mem_cmd_t    traffic_cmd,
    output logic             mem_wr,
    output mem_cmd_t         mem_cmd,
    output mem_src_e         mem_src,
    output logic [1:0]       overflow
);

    sample_rec_t s_rec;
    mem_cmd_t    s_cmd;
    mem_cmd_t    t_cmd;
    logic        s_empty;
    logic        t_empty;
    logic        pick_traffic;
    logic        pop_s;
    logic        pop_t;
    mem_src_e    grant_src;

    chain_fifo #(.payload_t(sample_rec_t)) i_sample_fifo (
        .pad_clk    (pad_clk),
        .pad_resetn (pad_resetn),
        .push       (sample_stb),
        .push_data  (sample_rec),
        .pop        (pop_s),
        .pop_data   (s_rec),
        .empty      (s_empty),
        .overflow   (overflow[0])
    );

    chain_fifo #(.payload_t(mem_cmd_t)) i_traffic_fifo (
        .pad_clk    (pad_clk),
        .pad_resetn (pad_resetn),
        .push       (traffic_stb),
        .push_data  (traffic_cmd),
        .pop        (pop_t),
        .pop_data   (t_cmd),
        .empty      (t_empty),
        .overflow   (overflow[1])
    );

    // Sample seq is the word offset in the sample region at address 0
    always_comb begin
        s_cmd.addr = mem_addr_t'(s_rec.seq);
        s_cmd.data = mem_data_t'(s_rec.data);
    end

    // Round robin: on a tie the source not served last wins
    always_comb begin
        if (!s_empty && !t_empty) begin
            pick_traffic = (mem_src == SRC_SAMPLE);
        end else begin
            pick_traffic = !t_empty;
        end
    end

    assign pop_s     = !s_empty && !pick_traffic;
    assign pop_t     = !t_empty && pick_traffic;
    assign grant_src = pick_traffic ? SRC_TRAFFIC : SRC_SAMPLE;

    // mem_src doubles as the last-grant state, traffic after reset so sample leads
    always_ff @(posedge pad_clk) begin
        if (!pad_resetn) begin
            mem_wr  <= 1'b0;
            mem_src <= SRC_TRAFFIC;
        end else begin
            mem_wr <= pop_s | pop_t;
            if (pop_s || pop_t) begin
                mem_src <= grant_src;
            end
        end
    end

    always_ff @(posedge pad_clk) begin
        if (pop_s || pop_t) begin
            mem_cmd <= pick_traffic ? t_cmd : s_cmd;
        end
    end

endmodule

`default_nettype wire

// File: rtl/traffic_chain_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

// Capture side of the chain: two producers merged onto one write port
module traffic_chain_top
    import mem_pkg::*;
(
    input  wire                       pad_clk,
    input  wire                       pad_resetn,
    input  wire [`SAMPLE_WIDTH-1:0]   sample_data_async,
    input  wire [15:0]                sw,               // Only sw[0] is used
    output logic                      mem_wr,
    output logic [`ADDR_WIDTH-1:0]    mem_addr,
    output logic [`SAMPLE_WIDTH-1:0]  mem_wdata,
    output logic                      mem_src,          // 0 sample, 1 traffic
    output logic [1:0]                overflow,
    output logic                      burst_busy
);

    logic                  sample_stb;
    sample_pkg::sample_rec_t sample_rec;
    logic                  traffic_stb;
    mem_cmd_t              traffic_cmd;
    mem_cmd_t              mem_cmd;

    sample_capture i_sample_capture (
        .pad_clk           (pad_clk),
        .pad_resetn        (pad_resetn),
        .sample_data_async (sample_data_async),
        .sample_stb        (sample_stb),
        .sample_rec        (sample_rec)
    );

    traffic_gen i_traffic_gen (
        .pad_clk      (pad_clk),
        .pad_resetn   (pad_resetn),
        .enable_async (sw[0]),
        .traffic_stb  (traffic_stb),
        .traffic_cmd  (traffic_cmd),
        .burst_busy   (burst_busy)
    );

    mem_arbiter i_mem_arbiter (
        .pad_clk     (pad_clk),
        .pad_resetn  (pad_resetn),
        .sample_stb  (sample_stb),
        .sample_rec  (sample_rec),
        .traffic_stb (traffic_stb),
        .traffic_cmd (traffic_cmd),
        .mem_wr      (mem_wr),
        .mem_cmd     (mem_cmd),
        .mem_src     (mem_src),
        .overflow    (overflow)
    );

    // Flatten the write command onto the board-facing pins
    assign mem_addr  = mem_cmd.addr;
    assign mem_wdata = mem_cmd.data;

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock plus a reset held for a fixed number of cycles
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,    // ns
    parameter int RESET_CYCLES = 10
) (
    output logic pad_clk,
    output logic pad_resetn
);

    initial begin
        pad_clk = 1'b0;
        forever begin
            #HALF_PERIOD pad_clk = ~pad_clk;
        end
    end

    initial begin
        pad_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge pad_clk);
        @(negedge pad_clk);     // Away from the testbench sampling points
        pad_resetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/traffic_chain_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

// Port-level rules of the merged write port
module traffic_chain_asserts
    import mem_pkg::*;
(
    input wire                   pad_clk,
    input wire                   pad_resetn,
    input wire                   mem_wr,
    input wire [`ADDR_WIDTH-1:0] mem_addr,
    input wire                   mem_src,
    input wire [1:0]             overflow
);

    int   fail_count = 0;
    logic in_reset_q = 1'b0;   // Reset already seen on an earlier edge

    always @(posedge pad_clk) begin
        in_reset_q <= !pad_resetn;
    end

    a_wr_in_reset: assert property (@(posedge pad_clk)
        (!pad_resetn && in_reset_q) |-> !mem_wr)
        else begin
            fail_count++;
            $error("mem_wr is high during reset");
        end

    // Each source stays inside its own address region
    a_sample_region: assert property (@(posedge pad_clk) disable iff (!pad_resetn)
        (mem_wr && mem_src == SRC_SAMPLE) |-> (mem_addr < `TRAFFIC_BASE))
        else begin
            fail_count++;
            $error("sample write at 0x%04h is in the traffic region", mem_addr);
        end

    a_traffic_region: assert property (@(posedge pad_clk) disable iff (!pad_resetn)
        (mem_wr && mem_src == SRC_TRAFFIC) |-> (mem_addr >= `TRAFFIC_BASE))
        else begin
            fail_count++;
            $error("traffic write at 0x%04h is in the sample region", mem_addr);
        end

    a_ovf_sticky_sample: assert property (@(posedge pad_clk) disable iff (!pad_resetn)
        overflow[0] |=> overflow[0])
        else begin
            fail_count++;
            $error("sample overflow bit cleared without reset");
        end

    a_ovf_sticky_traffic: assert property (@(posedge pad_clk) disable iff (!pad_resetn)
        overflow[1] |=> overflow[1])
        else begin
            fail_count++;
            $error("traffic overflow bit cleared without reset");
        end

endmodule

bind traffic_chain_top traffic_chain_asserts i_asserts (
    .pad_clk    (pad_clk),
    .pad_resetn (pad_resetn),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_src    (mem_src),
    .overflow   (overflow)
);

`default_nettype wire

// File: test/traffic_chain_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "chain_macros.svh"

module traffic_chain_tb
    import sample_pkg::*, mem_pkg::*;
();

    logic      pad_clk;
    logic      pad_resetn;
    sample_t   sample_data_async;
    logic [15:0] sw;
    logic      mem_wr;
    mem_addr_t mem_addr;
    mem_data_t mem_wdata;
    logic      mem_src;
    logic [1:0] overflow;
    logic      burst_busy;

    int          value_errors = 0;
    int          flow_errors = 0;
    logic [31:0] lfsr_q = 32'h814f_e0a4;
    sample_seq_t next_seq = '0;     // Seq expected for the next captured sample
    mem_cmd_t    sample_q[$];
    mem_cmd_t    traffic_q[$];

    tb_clock_gen i_clock_gen (
        .pad_clk    (pad_clk),
        .pad_resetn (pad_resetn)
    );

    traffic_chain_top i_dut (
        .pad_clk           (pad_clk),
        .pad_resetn        (pad_resetn),
        .sample_data_async (sample_data_async),
        .sw                (sw),
        .mem_wr            (mem_wr),
        .mem_addr          (mem_addr),
        .mem_wdata         (mem_wdata),
        .mem_src           (mem_src),
        .overflow          (overflow),
        .burst_busy        (burst_busy)
    );

    // Collect every write, split by source
    always @(posedge pad_clk) begin
        if (pad_resetn && mem_wr) begin
            if (mem_src == SRC_TRAFFIC) begin
                traffic_q.push_back('{addr: mem_addr, data: mem_wdata});
            end else begin
                sample_q.push_back('{addr: mem_addr, data: mem_wdata});
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Nonzero and different from the value on the bus now
    task automatic next_sample(output sample_t v);
        v = '0;
        while (v == '0 || v == sample_data_async) begin
            repeat (`SAMPLE_WIDTH) begin
                lfsr_q = lfsr_step(lfsr_q);
                v = {v[`SAMPLE_WIDTH-2:0], lfsr_q[0]};
            end
        end
    endtask

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge pad_clk);
            #10;
        end
    endtask

    task automatic check_cmd(input string name, input mem_cmd_t exp, input mem_cmd_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected addr 0x%04h data 0x%04h, actual addr 0x%04h data 0x%04h",
                     name, exp.addr, exp.data, act.addr, act.data);
        end
    endtask

    task automatic check_flag(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %0d writes, actual %0d", name, exp, act);
        end
    endtask

    // Wait for enough writes and then for an idle write port
    task automatic wait_writes(input string name, input int n_sample, input int n_traffic);
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        while ((quiet < 10 || sample_q.size() < n_sample || traffic_q.size() < n_traffic)
               && cycles < 1000) begin
            tick(1);
            cycles++;
            quiet = (mem_wr || burst_busy) ? 0 : quiet + 1;
        end
        if (cycles >= 1000) begin
            flow_errors++;
            $display("Timeout: %s, the writes never arrived or the port never went idle", name);
        end
    endtask

    task automatic start_burst(input string name);
        int cycles;
        sw[0] = 1'b1;
        tick(2);
        sw[0] = 1'b0;
        cycles = 0;
        while (burst_busy !== 1'b1 && cycles < 20) begin
            tick(1);
            cycles++;
        end
        if (burst_busy !== 1'b1) begin
            flow_errors++;
            $display("Timeout: %s, burst_busy never went high", name);
        end
    endtask

    task automatic expect_sample(input string name, input sample_t v);
        mem_cmd_t exp;
        if (sample_q.size() == 0) begin
            flow_errors++;
            $display("%s: the write for sample 0x%04h never appeared", name, v);
        end else begin
            exp.addr = mem_addr_t'(next_seq);   // Sample region starts at 0
            exp.data = v;
            check_cmd(name, exp, sample_q.pop_front());
        end
        next_seq++;
    endtask

    task automatic expect_burst(input string name);
        mem_cmd_t exp;
        int       i;
        check_count({name, " traffic"}, `BURST_LEN, traffic_q.size());
        for (i = 0; i < `BURST_LEN && traffic_q.size() > 0; i++) begin
            exp.addr = mem_addr_t'(`TRAFFIC_BASE + i);
            exp.data = mem_data_t'(exp.addr) ^ mem_data_t'(`TRAFFIC_MASK);
            check_cmd(name, exp, traffic_q.pop_front());
        end
    endtask

    task automatic test_reset();
        int cycles;
        cycles = 0;
        while (pad_resetn !== 1'b1 && cycles < 50) begin
            tick(1);
            cycles++;
        end
        if (pad_resetn !== 1'b1) begin
            flow_errors++;
            $display("Timeout: reset was never released");
        end
        check_flag("reset mem_wr", 2'b00, {1'b0, mem_wr});
        check_flag("reset burst_busy", 2'b00, {1'b0, burst_busy});
        check_flag("reset overflow", 2'b00, overflow);
        tick(20);   // Bus held at zero
        check_count("reset idle", 0, sample_q.size() + traffic_q.size());
    endtask

    task automatic test_single();
        sample_t v;
        next_sample(v);
        sample_data_async = v;
        wait_writes("single", 1, 0);
        check_count("single", 1, sample_q.size());
        expect_sample("single", v);
    endtask

    task automatic test_sequence();
        sample_t vals[10];
        int      i;
        for (i = 0; i < 10; i++) begin
            next_sample(vals[i]);
            sample_data_async = vals[i];
            tick(6);
        end
        wait_writes("sequence", 10, 0);
        check_count("sequence", 10, sample_q.size());
        for (i = 0; i < 10; i++) begin
            expect_sample("sequence", vals[i]);
        end
        sample_data_async = vals[9];    // Same value again
        tick(20);
        check_count("sequence repeat", 0, sample_q.size());
    endtask

    task automatic test_burst();
        start_burst("burst");
        tick(8);
        check_flag("burst busy", 2'b01, {1'b0, burst_busy});
        sw[0] = 1'b1;   // Second pulse inside the burst
        tick(2);
        sw[0] = 1'b0;
        wait_writes("burst", 0, `BURST_LEN);
        check_flag("burst done", 2'b00, {1'b0, burst_busy});
        check_count("burst sample", 0, sample_q.size());
        expect_burst("burst");
    endtask

    task automatic test_concurrent();
        sample_t vals[6];
        int      i;
        start_burst("concurrent");
        for (i = 0; i < 6; i++) begin
            next_sample(vals[i]);
            sample_data_async = vals[i];
            tick(4);
        end
        wait_writes("concurrent", 6, `BURST_LEN);
        check_count("concurrent sample", 6, sample_q.size());
        for (i = 0; i < 6; i++) begin
            expect_sample("concurrent", vals[i]);
        end
        expect_burst("concurrent");
        check_flag("concurrent overflow", 2'b00, overflow);
    endtask

    task automatic test_overflow();
        sample_t     vals[40];
        mem_cmd_t    cmd;
        mem_cmd_t    exp;
        sample_seq_t base;
        int          i;
        int          idx;
        int          last_idx;
        base = next_seq;
        start_burst("overflow");
        for (i = 0; i < 40; i++) begin
            next_sample(vals[i]);
            sample_data_async = vals[i];
            tick(1);
        end
        wait_writes("overflow", 1, 1);
        // Both sources push every cycle and each drains at half rate
        check_flag("overflow bits", 2'b11, overflow);
        if (sample_q.size() >= 40) begin
            flow_errors++;
            $display("overflow: all 40 samples were written, none was dropped");
        end
        last_idx = -1;
        while (sample_q.size() > 0) begin
            cmd = sample_q.pop_front();
            idx = int'(cmd.addr) - int'(base);  // Dropped samples still use up a seq
            if (idx <= last_idx || idx >= 40) begin
                flow_errors++;
                $display("overflow: sample write at 0x%04h is out of order", cmd.addr);
            end else begin
                exp.addr = cmd.addr;
                exp.data = vals[idx];
                check_cmd("overflow", exp, cmd);
                last_idx = idx;
            end
        end
    endtask

    initial begin
        sample_data_async = '0;
        sw = '0;
        test_reset();
        test_single();
        test_sequence();
        test_burst();
        test_concurrent();
        test_overflow();
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, flow_errors, i_dut.i_asserts.fail_count);
        if (value_errors == 0 && flow_errors == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: traffic_chain_top.f
+incdir+include
rtl/sample_pkg.sv
rtl/mem_pkg.sv
rtl/chain_fifo.sv
rtl/sample_capture.sv
rtl/traffic_gen.sv
rtl/mem_arbiter.sv
rtl/traffic_chain_top.sv
test/tb_clock_gen.sv
test/traffic_chain_asserts.sv
test/traffic_chain_tb.sv

// File: Bender.yml
package:
  name: traffic_chain

export_include_dirs:
  - include

sources:
  - files:
      - rtl/sample_pkg.sv
      - rtl/mem_pkg.sv
      - rtl/chain_fifo.sv
      - rtl/sample_capture.sv
      - rtl/traffic_gen.sv
      - rtl/mem_arbiter.sv
      - rtl/traffic_chain_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clock_gen.sv
      - test/traffic_chain_asserts.sv
      - test/traffic_chain_tb.sv
